/* design/flow_stats_config.svh */
`ifndef FLOW_STATS_CONFIG_SVH
`define FLOW_STATS_CONFIG_SVH

////////////////////////////////////////
// memory geometry
////////////////////////////////////////
`define FLOW_ADDR_W     6               // word address
`define FLOW_WORDS      64              // words cleared after calibration

////////////////////////////////////////
// slot fields
////////////////////////////////////////
`define FLOW_ID_W       16              // id 0 marks an empty slot
`define FLOW_PKT_W      16
`define FLOW_BYTES_W    32

////////////////////////////////////////
// request side and status
////////////////////////////////////////
`define FLOW_REQ_DEPTH  4               // pending updates
`define FLOW_MISS_W     16              // dropped request counter

`endif

/* design/flow_stats_pkg.sv */
`default_nettype none
`include "flow_stats_config.svh"

package flow_stats_pkg;

	// one flow entry of 64 bits
	typedef struct packed {
		logic [`FLOW_ID_W-1:0]    id;     // 0 when unused
		logic [`FLOW_PKT_W-1:0]   pkts;
		logic [`FLOW_BYTES_W-1:0] bytes;
	} flow_slot_t;

	localparam int SLOT_W = $bits(flow_slot_t);

	// a memory word is two slots side by side
	typedef union packed {
		logic [2*SLOT_W-1:0] raw;         // as the sram moves it
		flow_slot_t [1:0]    slot;        // slot 0 in the low half
	} flow_word_u;

endpackage

`default_nettype wire

/* design/flow_req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_req_fifo
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       push,
	input  wire  [`FLOW_ADDR_W-1:0]   push_addr,
	input  wire  [`FLOW_ID_W-1:0]     push_id,
	input  wire  [`FLOW_BYTES_W-1:0]  push_bytes,
	input  wire                       pop,
	output logic                      empty,
	output logic                      full,
	output logic [`FLOW_ADDR_W-1:0]   head_addr,
	output logic [`FLOW_ID_W-1:0]     head_id,
	output logic [`FLOW_BYTES_W-1:0]  head_bytes
);
	localparam int DEPTH = `FLOW_REQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	logic [`FLOW_ADDR_W-1:0]  addr_q  [DEPTH];
	logic [`FLOW_ID_W-1:0]    id_q    [DEPTH];
	logic [`FLOW_BYTES_W-1:0] bytes_q [DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     do_push;
	logic                     do_pop;

	assign do_push = push && !full;       // extra push while full is lost
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH));

	assign head_addr  = addr_q[rd_ptr];
	assign head_id    = id_q[rd_ptr];
	assign head_bytes = bytes_q[rd_ptr];

	////////////////////////////////////////
	// pointers and fill level
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			addr_q[wr_ptr]  <= push_addr;
			id_q[wr_ptr]    <= push_id;
			bytes_q[wr_ptr] <= push_bytes;
		end
	end

	// controller only pops a request it has already seen at the head
	no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

/* design/flow_slot_update.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_slot_update
(
	input  wire flow_stats_pkg::flow_slot_t slot,
	input  wire  [`FLOW_ID_W-1:0]           req_id,
	input  wire  [`FLOW_BYTES_W-1:0]        req_bytes,
	output logic                            match,
	output logic                            free,
	output flow_stats_pkg::flow_slot_t      new_slot
);
	localparam int PKT_W = `FLOW_PKT_W;

	always_comb
	begin
		match = (slot.id == req_id);
		free  = (slot.id == '0);          // never written since the clear
		new_slot.id = req_id;
		if (match)
		begin
			// same flow, accumulate
			new_slot.pkts  = slot.pkts + PKT_W'(1);
			new_slot.bytes = slot.bytes + req_bytes;
		end
		else
		begin
			// fresh entry, only used if the selector claims this slot
			new_slot.pkts  = PKT_W'(1);
			new_slot.bytes = req_bytes;
		end
	end

endmodule

`default_nettype wire

/* design/flow_slot_select.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_slot_select
(
	input  wire flow_stats_pkg::flow_word_u old_word,
	input  wire                             match0,
	input  wire                             free0,
	input  wire flow_stats_pkg::flow_slot_t new_slot0,
	input  wire                             match1,
	input  wire                             free1,
	input  wire flow_stats_pkg::flow_slot_t new_slot1,
	output flow_stats_pkg::flow_word_u      new_word,
	output logic                            hit
);

	always_comb
	begin
		new_word = old_word;              // untouched slot keeps its value
		hit      = 1'b1;
		if (match0)
		begin
			new_word.slot[0] = new_slot0;
		end
		else if (match1)
		begin
			new_word.slot[1] = new_slot1;
		end
		else if (free0)
		begin
			new_word.slot[0] = new_slot0;
		end
		else if (free1)
		begin
			new_word.slot[1] = new_slot1;
		end
		else
		begin
			hit = 1'b0;                   // both slots taken by other flows
		end

		// the rmw loop claims a slot only when neither matches,
		// so a real flow id never sits in both halves of a word
		// (two empty slots both match id 0, which is no flow)
		one_match: assert final ((match0 & match1 & ~free0) !== 1'b1);
	end

endmodule

`default_nettype wire

/* design/flow_rmw_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_rmw_ctrl
(
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             cal_done,
	input  wire                             fifo_empty,
	input  wire  [`FLOW_ADDR_W-1:0]         head_addr,
	input  wire                             mem_rd_valid,
	input  wire flow_stats_pkg::flow_word_u mem_rdata,
	input  wire flow_stats_pkg::flow_word_u new_word,
	input  wire                             hit,
	output logic                            pop,
	output logic                            mem_rd_en,
	output logic                            mem_wr_en,
	output logic [`FLOW_ADDR_W-1:0]         mem_addr,
	output flow_stats_pkg::flow_word_u      mem_wdata,
	output flow_stats_pkg::flow_word_u      read_word,
	output logic                            init_done,
	output logic [`FLOW_MISS_W-1:0]         miss_count
);
	typedef enum logic [2:0] {IDLE, CLEAR, READ, WAIT, MODIFY, WRITE} state_t;

	localparam int ADDR_W = `FLOW_ADDR_W;
	localparam int MISS_W = `FLOW_MISS_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`FLOW_WORDS - 1);

	state_t                     state;
	state_t                     state_next;
	logic [ADDR_W-1:0]          clr_addr;
	logic [ADDR_W-1:0]          req_addr;
	flow_stats_pkg::flow_word_u wdata_q;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (!init_done)
				begin
					if (cal_done)
						state_next = CLEAR;
				end
				else if (!fifo_empty)
					state_next = READ;
			end
			CLEAR:  if (clr_addr == LAST_ADDR) state_next = IDLE;
			READ:   state_next = WAIT;
			WAIT:   if (mem_rd_valid) state_next = MODIFY;
			MODIFY: state_next = hit ? WRITE : IDLE;   // a miss writes nothing back
			WRITE:  state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	////////////////////////////////////////
	// control state
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= IDLE;
			clr_addr   <= '0;
			init_done  <= 1'b0;
			miss_count <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == CLEAR)
			begin
				clr_addr <= (clr_addr == LAST_ADDR) ? '0 : clr_addr + ADDR_W'(1);
				if (clr_addr == LAST_ADDR)
					init_done <= 1'b1;    // sticky once the sweep ends
			end
			if (state == MODIFY && !hit)
				miss_count <= miss_count + MISS_W'(1);
		end
	end

	// request address, fetched word and merged word
	always_ff @(posedge clk)
	begin
		if (state == IDLE && init_done && !fifo_empty)
			req_addr <= head_addr;
		if (state == WAIT && mem_rd_valid)
			read_word <= mem_rdata;
		if (state == MODIFY)
			wdata_q <= new_word;
	end

	assign pop       = (state == MODIFY); // head stays valid for the slot units until here
	assign mem_rd_en = (state == READ);
	assign mem_wr_en = (state == CLEAR) || (state == WRITE);
	assign mem_addr  = (state == CLEAR) ? clr_addr : req_addr;
	assign mem_wdata = (state == CLEAR) ? '0 : wdata_q;

	// sram answers only the single outstanding read
	rd_valid_in_wait: assert property (@(posedge clk) disable iff (reset)
		mem_rd_valid |-> state == WAIT);

endmodule

`default_nettype wire

/* design/flow_stats_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_stats_top
(
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             req_valid,
	input  wire  [`FLOW_ADDR_W-1:0]         req_addr,
	input  wire  [`FLOW_ID_W-1:0]           req_id,
	input  wire  [`FLOW_BYTES_W-1:0]        req_bytes,
	output logic                            req_full,
	input  wire                             cal_done,
	output logic                            init_done,
	output logic [`FLOW_MISS_W-1:0]         miss_count,
	output logic                            mem_rd_en,
	output logic                            mem_wr_en,
	output logic [`FLOW_ADDR_W-1:0]         mem_addr,
	output flow_stats_pkg::flow_word_u      mem_wdata,
	input  wire flow_stats_pkg::flow_word_u mem_rdata,
	input  wire                             mem_rd_valid
);
	logic                       fifo_empty;
	logic                       pop;
	logic [`FLOW_ADDR_W-1:0]    head_addr;
	logic [`FLOW_ID_W-1:0]      head_id;
	logic [`FLOW_BYTES_W-1:0]   head_bytes;
	flow_stats_pkg::flow_word_u read_word;
	flow_stats_pkg::flow_word_u new_word;
	flow_stats_pkg::flow_slot_t new_slot0;
	flow_stats_pkg::flow_slot_t new_slot1;
	logic                       match0;
	logic                       match1;
	logic                       free0;
	logic                       free1;
	logic                       hit;

	flow_req_fifo req_fifo (
		.clk(clk), .reset(reset), .push(req_valid & ~req_full),
		.push_addr(req_addr), .push_id(req_id), .push_bytes(req_bytes), .pop(pop),
		.empty(fifo_empty), .full(req_full),
		.head_addr(head_addr), .head_id(head_id), .head_bytes(head_bytes));

	flow_rmw_ctrl rmw_ctrl (
		.clk(clk), .reset(reset), .cal_done(cal_done), .fifo_empty(fifo_empty),
		.head_addr(head_addr), .mem_rd_valid(mem_rd_valid), .mem_rdata(mem_rdata),
		.new_word(new_word), .hit(hit), .pop(pop), .mem_rd_en(mem_rd_en),
		.mem_wr_en(mem_wr_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.read_word(read_word), .init_done(init_done), .miss_count(miss_count));

	// one update unit per half of the fetched word
	flow_slot_update slot0_upd (.slot(read_word.slot[0]), .req_id(head_id),
		.req_bytes(head_bytes), .match(match0), .free(free0), .new_slot(new_slot0));
	flow_slot_update slot1_upd (.slot(read_word.slot[1]), .req_id(head_id),
		.req_bytes(head_bytes), .match(match1), .free(free1), .new_slot(new_slot1));

	flow_slot_select slot_sel (
		.old_word(read_word),
		.match0(match0), .free0(free0), .new_slot0(new_slot0),
		.match1(match1), .free1(free1), .new_slot1(new_slot1),
		.new_word(new_word), .hit(hit));

endmodule

`default_nettype wire

/* dv/flow_sram_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_sram_model
(
	input  wire                             clk,
	input  wire                             reset,
	input  wire  [2:0]                      latency,  // read delay in cycles, 1 to 4
	input  wire                             mem_rd_en,
	input  wire                             mem_wr_en,
	input  wire  [`FLOW_ADDR_W-1:0]         mem_addr,
	input  wire flow_stats_pkg::flow_word_u mem_wdata,
	output flow_stats_pkg::flow_word_u      mem_rdata,
	output logic                            mem_rd_valid
);
	flow_stats_pkg::flow_word_u mem [`FLOW_WORDS];    // testbench peeks here
	logic [`FLOW_ADDR_W-1:0]    pend_addr;
	logic [2:0]                 wait_cnt;

	// power-up garbage so a skipped clear is visible
	initial
	begin
		for (int a = 0; a < `FLOW_WORDS; a++)
			mem[a] <= {4{32'hc0de_0000 | 32'(a)}};
	end

	always @(posedge clk)
	begin
		mem_rd_valid <= 1'b0;
		if (mem_wr_en)
			mem[mem_addr] <= mem_wdata;
		if (reset)
			wait_cnt <= '0;
		else if (mem_rd_en)
		begin
			pend_addr <= mem_addr;
			wait_cnt  <= latency - 3'd1;
			if (latency == 3'd1)
			begin
				mem_rd_valid <= 1'b1;       // answer on the next cycle
				mem_rdata    <= mem[mem_addr];
			end
		end
		else if (wait_cnt != '0)
		begin
			wait_cnt <= wait_cnt - 3'd1;
			if (wait_cnt == 3'd1)
			begin
				mem_rd_valid <= 1'b1;
				mem_rdata    <= mem[pend_addr];
			end
		end
	end

endmodule

`default_nettype wire

/* dv/flow_stats_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "flow_stats_config.svh"

module flow_stats_tb;
	localparam int NUM_RANDOM = 40;
	localparam int MAX_CYCLES = 64 + NUM_RANDOM * (8 + 4) * 2;
	localparam logic [`FLOW_ADDR_W-1:0] HOT_ADDR = `FLOW_ADDR_W'(5);   // directed tests

	logic                       clk = 1'b0;
	logic                       reset;
	logic                       cal_done;
	logic                       req_valid;
	logic [`FLOW_ADDR_W-1:0]    req_addr;
	logic [`FLOW_ID_W-1:0]      req_id;
	logic [`FLOW_BYTES_W-1:0]   req_bytes;
	logic                       req_full;
	logic                       init_done;
	logic [`FLOW_MISS_W-1:0]    miss_count;
	logic                       mem_rd_en;
	logic                       mem_wr_en;
	logic [`FLOW_ADDR_W-1:0]    mem_addr;
	flow_stats_pkg::flow_word_u mem_wdata;
	flow_stats_pkg::flow_word_u mem_rdata;
	logic                       mem_rd_valid;
	logic [2:0]                 rd_latency;

	logic [31:0]                lfsr = 32'h4439_21dd;
	flow_stats_pkg::flow_word_u model [`FLOW_WORDS];   // expected memory contents
	int                         exp_misses = 0;
	int                         sent = 0;
	int                         updates = 0;            // write-backs after init
	int                         clear_writes = 0;
	int                         cycles = 0;
	int                         checks = 0;
	int                         errors = 0;
	logic                       saw_full = 1'b0;
	logic                       init_seen = 1'b0;

	flow_stats_top dut (.*);
	flow_sram_model sram (.latency(rd_latency), .*);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic flow_stats_pkg::flow_slot_t make_slot(input int id, input int pkts,
		input int bytes);
		return '{id: `FLOW_ID_W'(id), pkts: `FLOW_PKT_W'(pkts), bytes: `FLOW_BYTES_W'(bytes)};
	endfunction

	task automatic check_val(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		value_ok: assert (actual === expected)
		else
		begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_mem(input string name);
		for (int a = 0; a < `FLOW_WORDS; a++)
			check_val($sformatf("%s word %0d", name, a), model[`FLOW_ADDR_W'(a)].raw,
				sram.mem[`FLOW_ADDR_W'(a)].raw);
	endtask

	// one request through the slot rules
	task automatic apply_model(input int addr, input int id, input int bytes);
		flow_stats_pkg::flow_word_u w;
		logic [`FLOW_ADDR_W-1:0]    a;
		a = `FLOW_ADDR_W'(addr);
		w = model[a];
		if (w.slot[0].id == `FLOW_ID_W'(id) || w.slot[1].id == `FLOW_ID_W'(id))
		begin
			if (w.slot[0].id == `FLOW_ID_W'(id))
				w.slot[0] = make_slot(id, int'(w.slot[0].pkts) + 1, int'(w.slot[0].bytes) + bytes);
			else
				w.slot[1] = make_slot(id, int'(w.slot[1].pkts) + 1, int'(w.slot[1].bytes) + bytes);
		end
		else if (w.slot[0].id == '0)
			w.slot[0] = make_slot(id, 1, bytes);
		else if (w.slot[1].id == '0)
			w.slot[1] = make_slot(id, 1, bytes);
		else
			exp_misses++;           // both slots owned by other flows
		model[a] = w;
	endtask

	// called at a rising edge, returns at the edge that takes the request
	task automatic send_req(input int addr, input int id, input int bytes);
		req_valid  <= 1'b1;
		req_addr   <= `FLOW_ADDR_W'(addr);
		req_id     <= `FLOW_ID_W'(id);
		req_bytes  <= `FLOW_BYTES_W'(bytes);
		rd_latency <= 3'(take_bits(2)) + 3'd1;
		@(negedge clk);
		while (req_full)
			@(negedge clk);
		@(posedge clk);
		apply_model(addr, id, bytes);
		sent++;
	endtask

	task automatic settle();
		req_valid <= 1'b0;
		@(negedge clk);
		while (updates + int'(miss_count) != sent)
			@(negedge clk);
	endtask

	////////////////////////////////////////
	// monitors and timeout
	////////////////////////////////////////
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (mem_wr_en && !init_done)
			clear_writes <= clear_writes + 1;
		if (mem_wr_en && init_done)
			updates <= updates + 1;
		if (req_full)
			saw_full <= 1'b1;
		if (cycles == MAX_CYCLES)
		begin
			$display("timeout after %0d cycles with %0d of %0d requests done",
				cycles, updates + int'(miss_count), sent);
			$display("Simulation FAILED");
			$finish;
		end
	end

	always @(negedge clk)
	begin
		if (init_done && !init_seen)
		begin
			init_seen = 1'b1;
			check_val("clear_writes", 128'(`FLOW_WORDS), 128'(clear_writes));
		end
		if (!reset)
		begin
			rd_wr_apart: assert (!(mem_rd_en && mem_wr_en))
			else
			begin
				errors++;
				$display("read and write enables high together in cycle %0d", cycles);
			end
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial
	begin
		flow_stats_pkg::flow_word_u full_word;
		int                         addr;
		int                         id;
		int                         bytes;
		for (int a = 0; a < `FLOW_WORDS; a++)
			model[`FLOW_ADDR_W'(a)] = '0;
		reset      <= 1'b1;
		cal_done   <= 1'b0;
		req_valid  <= 1'b0;
		req_addr   <= '0;
		req_id     <= '0;
		req_bytes  <= '0;
		rd_latency <= 3'd1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("reset_outputs", '0,
			128'({mem_rd_en, mem_wr_en, init_done, req_full, miss_count}));
		@(posedge clk);
		cal_done <= 1'b1;
		@(negedge clk);
		while (!init_done)
			@(negedge clk);
		check_mem("clear");

		@(posedge clk);
		send_req(int'(HOT_ADDR), 7, 100);
		settle();
		check_val("first_flow", 128'(make_slot(7, 1, 100)), 128'(sram.mem[HOT_ADDR].slot[0]));

		@(posedge clk);
		send_req(int'(HOT_ADDR), 7, 20);
		send_req(int'(HOT_ADDR), 7, 30);
		send_req(int'(HOT_ADDR), 7, 40);
		settle();
		check_val("accumulate", 128'(make_slot(7, 4, 190)), 128'(sram.mem[HOT_ADDR].slot[0]));

		@(posedge clk);
		send_req(int'(HOT_ADDR), 9, 55);
		settle();
		check_val("second_flow", 128'(make_slot(9, 1, 55)), 128'(sram.mem[HOT_ADDR].slot[1]));
		check_val("slot0_kept", 128'(make_slot(7, 4, 190)), 128'(sram.mem[HOT_ADDR].slot[0]));
		full_word.slot[0] = make_slot(7, 4, 190);
		full_word.slot[1] = make_slot(9, 1, 55);

		@(posedge clk);
		send_req(int'(HOT_ADDR), 11, 60);       // no room left for a third flow
		settle();
		check_val("miss_word", full_word.raw, sram.mem[HOT_ADDR].raw);
		check_val("miss_count", 128'(1), 128'(miss_count));
		check_mem("directed");

		// back to back with ids 1 to 5 over four words
		@(posedge clk);
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			addr  = int'(take_bits(2));
			id    = int'(take_bits(3) % 5) + 1;
			bytes = int'(take_bits(10));
			send_req(addr, id, bytes);
		end
		settle();
		check_mem("random");
		check_val("random_misses", 128'(exp_misses), 128'(miss_count));
		check_val("queue_filled", 128'(1), 128'(saw_full));

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/flow_stats_pkg.sv
design/flow_req_fifo.sv
design/flow_slot_update.sv
design/flow_slot_select.sv
design/flow_rmw_ctrl.sv
design/flow_stats_top.sv
dv/flow_sram_model.sv
dv/flow_stats_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module flow_stats_tb -f files.f -o flow_stats_sim \
	> sim.log 2>&1 &&
./obj_dir/flow_stats_sim >> sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "run passed, see sim.log" ||
	{ echo "run failed, see sim.log"; exit 1; }
